// File: filelist.f
dma_fe_pkg.sv
dma_inst_decode.sv
dma_req_fifo.sv
dma_nd_midend.sv
dma_rsp_spill.sv
dma_inst_frontend.sv
dma_fe_checker.sv
tb_dma_frontend.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the DMA frontend testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_dma_frontend -f filelist.f

out=$(./obj_dir/Vtb_dma_frontend)
echo "$out"

if grep -qx "Test OK" <<< "$out"; then
    exit 0
else
    exit 1
fi

// File: tb_dma_frontend.sv
/*
  testbench of the DMA instruction frontend
  status is read only with the engine drained or with bursts blocked,
  and the model takes busy and full from that known state
*/
`timescale 1ns/1ps

module tb_dma_frontend
    import dma_fe_pkg::*;
();

    // instruction count of the whole program sets the watchdog
    localparam int N_INSTR   = 69;
    localparam int WD_CYCLES = 200 * N_INSTR;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    acc_req_t   acc_req = '0;
    logic       acc_req_valid = 1'b0;
    logic       acc_req_ready;
    acc_rsp_t   acc_rsp;
    logic       acc_rsp_valid;
    logic       acc_rsp_ready = 1'b0;
    burst_req_t burst;
    logic       burst_valid;
    logic       burst_ready = 1'b0;
    logic       busy;

    // expectations and their stream into the checker
    acc_rsp_t   exp_rsp_q[$];
    burst_req_t exp_burst_q[$];
    acc_rsp_t   exp_rsp = '0;
    logic       exp_rsp_push = 1'b0;
    burst_req_t exp_burst = '0;
    logic       exp_burst_push = 1'b0;
    logic       busy_exp = 1'b0;
    logic       busy_chk = 1'b0;
    int         test_id = 0;
    logic       test_end = 1'b0;
    logic       pending;
    int         errors;
    int         checks;

    // reference model state
    addr_t      src_m;
    addr_t      dst_m;
    rep_t       sstr_m;
    rep_t       dstr_m;
    rep_t       reps_m;
    tf_id_t     next_m;
    tf_id_t     copies_m;
    logic       busy_m;
    logic       full_m;
    acc_id_t    tag_n;

    logic        rand_ready = 1'b0;
    logic        burst_stall = 1'b0;
    integer      rdy_seed = 32'ha9b9;
    integer      stim_seed = 32'ha9b9 + 1;
    logic [31:0] rnd;

    always #5 clk = ~clk;

    dma_inst_frontend dma_inst_frontend_inst (
        .clk_i           (clk),
        .rst_i           (rst),
        .acc_req_i       (acc_req),
        .acc_req_valid_i (acc_req_valid),
        .acc_req_ready_o (acc_req_ready),
        .acc_rsp_o       (acc_rsp),
        .acc_rsp_valid_o (acc_rsp_valid),
        .acc_rsp_ready_i (acc_rsp_ready),
        .burst_o         (burst),
        .burst_valid_o   (burst_valid),
        .burst_ready_i   (burst_ready),
        .busy_o          (busy)
    );

    dma_fe_checker dma_fe_checker_inst (
        .clk_i            (clk),
        .rst_i            (rst),
        .acc_rsp_i        (acc_rsp),
        .acc_rsp_valid_i  (acc_rsp_valid),
        .acc_rsp_ready_i  (acc_rsp_ready),
        .burst_i          (burst),
        .burst_valid_i    (burst_valid),
        .burst_ready_i    (burst_ready),
        .busy_i           (busy),
        .exp_rsp_i        (exp_rsp),
        .exp_rsp_push_i   (exp_rsp_push),
        .exp_burst_i      (exp_burst),
        .exp_burst_push_i (exp_burst_push),
        .busy_exp_i       (busy_exp),
        .busy_chk_i       (busy_chk),
        .test_id_i        (test_id),
        .test_end_i       (test_end),
        .pending_o        (pending),
        .errors_o         (errors),
        .checks_o         (checks)
    );

    // one expectation of each kind per cycle into the checker
    always @(posedge clk) begin
        exp_rsp_push   <= 1'b0;
        exp_burst_push <= 1'b0;
        if (exp_rsp_q.size() != 0) begin
            exp_rsp      <= exp_rsp_q.pop_front();
            exp_rsp_push <= 1'b1;
        end
        if (exp_burst_q.size() != 0) begin
            exp_burst      <= exp_burst_q.pop_front();
            exp_burst_push <= 1'b1;
        end
    end

    // back-pressure on the burst and response channels
    always @(posedge clk) begin
        rnd = $random(rdy_seed);
        if (rand_ready) begin
            burst_ready   <= rnd[0] && !burst_stall;
            acc_rsp_ready <= rnd[1];
        end else begin
            burst_ready   <= !burst_stall;
            acc_rsp_ready <= 1'b1;
        end
    end

    function automatic acc_data_t rand_word();
        return $random(stim_seed);
    endfunction

    // --------------------
    // reference model
    // --------------------
    function automatic void ref_model(input acc_req_t req);
        acc_rsp_t   rsp;
        burst_req_t b;
        rep_t       n;
        rep_t       k;
        rsp.tag   = req.tag;
        rsp.error = 1'b0;
        rsp.data  = '0;
        case (req.op)
            DMSRC: src_m = req.arga;
            DMDST: dst_m = req.arga;
            DMSTR: begin
                sstr_m = req.arga;
                dstr_m = req.argb;
            end
            DMREP: reps_m = req.arga;
            DMCPY: begin
                // 1D mode or reps of 0 gives one burst
                n = (req.argb[1] && (reps_m != '0)) ? reps_m : rep_t'(1);
                k = '0;
                while (k < n) begin
                    b.src = src_m + k * sstr_m;
                    b.dst = dst_m + k * dstr_m;
                    b.len = req.arga;
                    exp_burst_q.push_back(b);
                    k = k + rep_t'(1);
                end
                rsp.data = next_m;
                next_m   = next_m + tf_id_t'(1);
                copies_m = copies_m + tf_id_t'(1);
                exp_rsp_q.push_back(rsp);
            end
            DMSTAT: begin
                case (req.argb[1:0])
                    2'd0:    rsp.data = copies_m;
                    2'd1:    rsp.data = next_m;
                    2'd2:    rsp.data = acc_data_t'(busy_m);
                    default: rsp.data = acc_data_t'(full_m);
                endcase
                exp_rsp_q.push_back(rsp);
            end
            default: begin
                rsp.error = 1'b1;
                exp_rsp_q.push_back(rsp);
            end
        endcase
    endfunction

    task automatic send_instr(input logic [2:0] op, input acc_data_t a, input acc_data_t b);
        acc_req_t req;
        req.tag  = tag_n;
        req.op   = dma_op_e'(op);
        req.arga = a;
        req.argb = b;
        tag_n    = tag_n + acc_id_t'(1);
        @(posedge clk);
        ref_model(req);
        acc_req       <= req;
        acc_req_valid <= 1'b1;
        do @(posedge clk);
        while (!acc_req_ready);
        acc_req_valid <= 1'b0;
    endtask

    // wait until every expectation is matched and the engine is idle
    task automatic finish_test();
        do @(posedge clk);
        while (exp_rsp_q.size() != 0 || exp_burst_q.size() != 0 || exp_rsp_push ||
               exp_burst_push || pending || busy);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    // --------------------
    // stimulus program
    // --------------------
    initial begin
        src_m    = '0;
        dst_m    = '0;
        sstr_m   = '0;
        dstr_m   = '0;
        reps_m   = '0;
        next_m   = tf_id_t'(1);
        copies_m = '0;
        busy_m   = 1'b0;
        full_m   = 1'b0;
        tag_n    = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // reps is set, so only the 1D mode keeps this to a single burst
        test_id <= 1;
        send_instr(DMREP, 32'd3, '0);
        send_instr(DMSRC, 32'h0000_1000, '0);
        send_instr(DMDST, 32'h0000_2000, '0);
        send_instr(DMCPY, 32'd64, '0);
        finish_test();

        // source address wraps past 2^32
        test_id <= 2;
        send_instr(DMSTR, 32'h0000_0100, 32'h0000_0040);
        send_instr(DMREP, 32'd4, '0);
        send_instr(DMSRC, 32'hffff_ff00, '0);
        send_instr(DMDST, 32'h0002_0000, '0);
        send_instr(DMCPY, 32'h0000_0080, 32'h2);
        finish_test();

        test_id    <= 3;
        rand_ready <= 1'b1;
        repeat (10) begin
            send_instr(DMSRC, rand_word(), '0);
            send_instr(DMDST, rand_word(), '0);
            send_instr(DMSTR, rand_word(), rand_word());
            send_instr(DMREP, rand_word() & 32'h3, '0);
            send_instr(DMCPY, rand_word(), rand_word() & 32'h2);
        end
        rand_ready <= 1'b0;
        finish_test();

        test_id <= 4;
        busy_m = 1'b0;
        full_m = 1'b0;
        send_instr(DMSTAT, '0, 32'd0);
        send_instr(DMSTAT, '0, 32'd1);
        send_instr(DMSTAT, '0, 32'd2);
        finish_test();

        // one job held in the midend and three waiting in the FIFO
        test_id     <= 5;
        burst_stall <= 1'b1;
        busy_m = 1'b1;
        full_m = 1'b1;
        repeat (4) send_instr(DMCPY, 32'd16, '0);
        send_instr(DMSTAT, '0, 32'd3);
        @(posedge clk);
        busy_exp <= 1'b1;
        busy_chk <= 1'b1;
        @(posedge clk);
        busy_chk    <= 1'b0;
        burst_stall <= 1'b0;
        finish_test();

        test_id <= 6;
        send_instr(3'd6, 32'h0000_1234, 32'h0000_5678);
        send_instr(3'd7, 32'hdead_0001, 32'h0000_0003);
        finish_test();

        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("watchdog expired, the DMA frontend stopped making progress");
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: dma_fe_checker.sv
/*
  watches the DUT response and burst channels and compares them in order
  expectations arrive on a push stream and must get here before the
  matching DUT output, so the testbench queues them before each request
*/
`timescale 1ns/1ps

module dma_fe_checker
    import dma_fe_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  acc_rsp_t   acc_rsp_i,
    input  logic       acc_rsp_valid_i,
    input  logic       acc_rsp_ready_i,
    input  burst_req_t burst_i,
    input  logic       burst_valid_i,
    input  logic       burst_ready_i,
    input  logic       busy_i,
    input  acc_rsp_t   exp_rsp_i,
    input  logic       exp_rsp_push_i,
    input  burst_req_t exp_burst_i,
    input  logic       exp_burst_push_i,
    input  logic       busy_exp_i,
    input  logic       busy_chk_i,
    input  int         test_id_i,
    input  logic       test_end_i,
    output logic       pending_o,
    output int         errors_o,
    output int         checks_o
);

    acc_rsp_t   rsp_q[$];
    burst_req_t burst_q[$];
    acc_rsp_t   rsp_exp;
    burst_req_t burst_exp;
    int         n_err = 0;
    int         n_chk = 0;
    int         test_err = 0;
    int         test_chk = 0;

    assign errors_o = n_err;
    assign checks_o = n_chk;

    function automatic string test_name(int id);
        case (id)
            1:       return "copy_1d";
            2:       return "copy_2d";
            3:       return "random_ready";
            4:       return "status_idle";
            5:       return "status_full";
            6:       return "invalid_op";
            default: return "setup";
        endcase
    endfunction

    task automatic count_check(input logic ok);
        n_chk    = n_chk + 1;
        test_chk = test_chk + 1;
        if (!ok) begin
            n_err    = n_err + 1;
            test_err = test_err + 1;
        end
    endtask

    always @(posedge clk_i) begin
        if (rst_i) begin
            pending_o <= 1'b0;
        end else begin
            // new expectations first, they may match an output at this edge
            if (exp_rsp_push_i) rsp_q.push_back(exp_rsp_i);
            if (exp_burst_push_i) burst_q.push_back(exp_burst_i);

            // --------------------
            // response channel
            // --------------------
            if (acc_rsp_valid_i && acc_rsp_ready_i) begin
                if (rsp_q.size() == 0) begin
                    $display("ERROR %s: a response arrived while none was expected",
                             test_name(test_id_i));
                    count_check(1'b0);
                end else begin
                    rsp_exp = rsp_q.pop_front();
                    count_check(acc_rsp_i === rsp_exp);
                    if (acc_rsp_i !== rsp_exp)
                        $display("FAIL %s: response expected %h, actual %h",
                                 test_name(test_id_i), rsp_exp, acc_rsp_i);
                end
            end

            // --------------------
            // burst channel
            // --------------------
            if (burst_valid_i && burst_ready_i) begin
                if (burst_q.size() == 0) begin
                    $display("ERROR %s: a burst left while none was expected",
                             test_name(test_id_i));
                    count_check(1'b0);
                end else begin
                    burst_exp = burst_q.pop_front();
                    count_check(burst_i === burst_exp);
                    if (burst_i !== burst_exp)
                        $display("FAIL %s: burst expected %h, actual %h",
                                 test_name(test_id_i), burst_exp, burst_i);
                end
            end

            if (busy_chk_i) begin
                count_check(busy_i === busy_exp_i);
                if (busy_i !== busy_exp_i)
                    $display("FAIL %s: busy expected %b, actual %b",
                             test_name(test_id_i), busy_exp_i, busy_i);
            end

            if (test_end_i) begin
                $display("test %0d %s: %s, %0d checks, %0d errors", test_id_i,
                         test_name(test_id_i), (test_err == 0) ? "pass" : "fail",
                         test_chk, test_err);
                test_err = 0;
                test_chk = 0;
            end

            pending_o <= (rsp_q.size() != 0) || (burst_q.size() != 0);
        end
    end

endmodule

// File: dma_inst_frontend.sv
/*
  DMA instruction frontend top level
  single channel, bursts leave to an external copy backend
  a transfer completes when its last burst is handed off
*/
`timescale 1ns/1ps

module dma_inst_frontend
    import dma_fe_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  acc_req_t   acc_req_i,
    input  logic       acc_req_valid_i,
    output logic       acc_req_ready_o,
    output acc_rsp_t   acc_rsp_o,
    output logic       acc_rsp_valid_o,
    input  logic       acc_rsp_ready_i,
    output burst_req_t burst_o,
    output logic       burst_valid_o,
    input  logic       burst_ready_i,
    output logic       busy_o
);

    nd_job_t  dec_job;
    logic     dec_job_valid;
    logic     dec_job_ready;
    nd_job_t  fifo_job;
    logic     fifo_job_valid;
    logic     fifo_job_ready;
    logic     fifo_full;
    logic     fifo_not_empty;
    logic     mid_busy;
    logic     job_done;
    acc_rsp_t dec_rsp;
    logic     dec_rsp_valid;
    logic     dec_rsp_ready;

    dma_inst_decode dma_inst_decode_inst (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .acc_req_i       (acc_req_i),
        .acc_req_valid_i (acc_req_valid_i),
        .acc_req_ready_o (acc_req_ready_o),
        .job_o           (dec_job),
        .job_valid_o     (dec_job_valid),
        .job_ready_i     (dec_job_ready),
        .fifo_full_i     (fifo_full),
        .busy_i          ({fifo_not_empty, mid_busy}),
        .busy_o          (busy_o),
        .job_done_i      (job_done),
        .rsp_o           (dec_rsp),
        .rsp_valid_o     (dec_rsp_valid),
        .rsp_ready_i     (dec_rsp_ready)
    );

    dma_req_fifo dma_req_fifo_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .job_i       (dec_job),
        .job_valid_i (dec_job_valid),
        .job_ready_o (dec_job_ready),
        .job_o       (fifo_job),
        .job_valid_o (fifo_job_valid),
        .job_ready_i (fifo_job_ready),
        .full_o      (fifo_full),
        .not_empty_o (fifo_not_empty)
    );

    dma_nd_midend dma_nd_midend_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .job_i         (fifo_job),
        .job_valid_i   (fifo_job_valid),
        .job_ready_o   (fifo_job_ready),
        .burst_o       (burst_o),
        .burst_valid_o (burst_valid_o),
        .burst_ready_i (burst_ready_i),
        .job_done_o    (job_done),
        .busy_o        (mid_busy)
    );

    dma_rsp_spill dma_rsp_spill_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rsp_i       (dec_rsp),
        .rsp_valid_i (dec_rsp_valid),
        .rsp_ready_o (dec_rsp_ready),
        .rsp_o       (acc_rsp_o),
        .rsp_valid_o (acc_rsp_valid_o),
        .rsp_ready_i (acc_rsp_ready_i)
    );

endmodule

// File: dma_rsp_spill.sv
/*
  two-entry response buffer with a registered output
  ready depends only on the occupancy, so the external ready
  has no combinational path back to the request side
*/
`timescale 1ns/1ps

module dma_rsp_spill
    import dma_fe_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  acc_rsp_t rsp_i,
    input  logic     rsp_valid_i,
    output logic     rsp_ready_o,
    output acc_rsp_t rsp_o,
    output logic     rsp_valid_o,
    input  logic     rsp_ready_i
);

    // slot 0 is the head, slot 1 only holds when slot 0 does
    acc_rsp_t slot0_q;
    acc_rsp_t slot1_q;
    logic     full0_q;
    logic     full1_q;
    logic     push;
    logic     pop;

    assign rsp_o       = slot0_q;
    assign rsp_valid_o = full0_q;
    assign rsp_ready_o = !full1_q;

    assign push = rsp_valid_i && rsp_ready_o;
    assign pop  = rsp_valid_o && rsp_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            full0_q <= 1'b0;
            full1_q <= 1'b0;
        end else if (pop) begin
            if (full1_q) begin
                slot0_q <= slot1_q;
                full1_q <= 1'b0;
            end else if (push) begin
                slot0_q <= rsp_i;
            end else begin
                full0_q <= 1'b0;
            end
        end else if (push) begin
            if (!full0_q) begin
                slot0_q <= rsp_i;
                full0_q <= 1'b1;
            end else begin
                slot1_q <= rsp_i;
                full1_q <= 1'b1;
            end
        end
    end

endmodule

// File: dma_nd_midend.sv
/*
  expands a 2D job into reps strided 1D bursts
  reps must be at least 1, the decoder guarantees this
  a new job is taken only once the previous one has fully left
*/
`timescale 1ns/1ps

module dma_nd_midend
    import dma_fe_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  nd_job_t    job_i,
    input  logic       job_valid_i,
    output logic       job_ready_o,
    output burst_req_t burst_o,
    output logic       burst_valid_o,
    input  logic       burst_ready_i,
    output logic       job_done_o,
    output logic       busy_o
);

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } state_e;

    state_e state_q;
    rep_t   rem_q;
    addr_t  src_q;
    addr_t  dst_q;
    len_t   len_q;
    rep_t   src_stride_q;
    rep_t   dst_stride_q;
    logic   take;
    logic   step;
    logic   last;

    assign job_ready_o   = (state_q == ST_IDLE);
    assign burst_valid_o = (state_q == ST_RUN);
    assign busy_o        = (state_q == ST_RUN);

    assign burst_o.src = src_q;
    assign burst_o.dst = dst_q;
    assign burst_o.len = len_q;

    assign take       = job_valid_i && job_ready_o;
    assign step       = burst_valid_o && burst_ready_i;
    assign last       = (rem_q == rep_t'(1));
    assign job_done_o = step && last;

    // --------------------
    // control
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            rem_q   <= '0;
        end else if (take) begin
            state_q <= ST_RUN;
            rem_q   <= job_i.reps;
        end else if (step) begin
            rem_q <= rem_q - rep_t'(1);
            if (last) state_q <= ST_IDLE;
        end
    end

    // running addresses, wrap modulo 2^32
    always_ff @(posedge clk_i) begin
        if (take) begin
            src_q        <= job_i.burst.src;
            dst_q        <= job_i.burst.dst;
            len_q        <= job_i.burst.len;
            src_stride_q <= job_i.src_stride;
            dst_stride_q <= job_i.dst_stride;
        end else if (step) begin
            src_q <= src_q + addr_t'(src_stride_q);
            dst_q <= dst_q + addr_t'(dst_stride_q);
        end
    end

endmodule

// File: dma_req_fifo.sv
/*
  circular FIFO of transfer jobs, REQ_FIFO_DEPTH entries
  a push shows at the output on the next edge, no bypass
*/
`timescale 1ns/1ps

module dma_req_fifo
    import dma_fe_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  nd_job_t job_i,
    input  logic    job_valid_i,
    output logic    job_ready_o,
    output nd_job_t job_o,
    output logic    job_valid_o,
    input  logic    job_ready_i,
    output logic    full_o,
    output logic    not_empty_o
);

    nd_job_t                   mem [REQ_FIFO_DEPTH];
    logic [REQ_FIFO_PTR_W-1:0] wr_ptr_q;
    logic [REQ_FIFO_PTR_W-1:0] rd_ptr_q;
    logic [REQ_FIFO_CNT_W-1:0] count_q;
    logic                      push;
    logic                      pop;

    assign full_o      = (count_q == REQ_FIFO_CNT_W'(REQ_FIFO_DEPTH));
    assign not_empty_o = (count_q != '0);
    assign job_ready_o = !full_o;
    assign job_valid_o = not_empty_o;
    assign job_o       = mem[rd_ptr_q];

    assign push = job_valid_i && job_ready_o;
    assign pop  = job_valid_o && job_ready_i;

    // storage has no reset
    always_ff @(posedge clk_i) begin
        if (push) mem[wr_ptr_q] <= job_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == REQ_FIFO_PTR_W'(REQ_FIFO_DEPTH - 1)) ?
                            '0 : wr_ptr_q + REQ_FIFO_PTR_W'(1);
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == REQ_FIFO_PTR_W'(REQ_FIFO_DEPTH - 1)) ?
                            '0 : rd_ptr_q + REQ_FIFO_PTR_W'(1);
            end
            if (push && !pop) count_q <= count_q + REQ_FIFO_CNT_W'(1);
            else if (pop && !push) count_q <= count_q - REQ_FIFO_CNT_W'(1);
        end
    end

endmodule

// File: dma_inst_decode.sv
/*
  instruction decoder with the configuration registers and transfer-id counters
  requests are answered combinationally in the cycle they are presented
  the downstream job and response channels must accept in that same cycle
  busy_i bit 1 is the request FIFO not-empty flag, bit 0 the midend busy flag
*/
`timescale 1ns/1ps

module dma_inst_decode
    import dma_fe_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  acc_req_t   acc_req_i,
    input  logic       acc_req_valid_i,
    output logic       acc_req_ready_o,
    output nd_job_t    job_o,
    output logic       job_valid_o,
    input  logic       job_ready_i,
    input  logic       fifo_full_i,
    input  logic [1:0] busy_i,
    output logic       busy_o,
    input  logic       job_done_i,
    output acc_rsp_t   rsp_o,
    output logic       rsp_valid_o,
    input  logic       rsp_ready_i
);

    // configuration registers
    addr_t  src_q;
    addr_t  dst_q;
    rep_t   src_stride_q;
    rep_t   dst_stride_q;
    rep_t   reps_q;
    tf_id_t next_id_q;
    tf_id_t completed_id_q;

    logic   twod;
    logic   issue;
    logic   wr_src;
    logic   wr_dst;
    logic   wr_str;
    logic   wr_rep;

    assign busy_o = |busy_i;

    // 2D only when asked for and reps is set, otherwise a single burst
    assign twod = acc_req_i.argb[1];

    always_comb begin
        job_o.burst.src  = src_q;
        job_o.burst.dst  = dst_q;
        job_o.burst.len  = len_t'(acc_req_i.arga);
        job_o.src_stride = src_stride_q;
        job_o.dst_stride = dst_stride_q;
        job_o.reps       = (twod && (reps_q != '0)) ? reps_q : rep_t'(1);
    end

    // --------------------
    // decode
    // --------------------
    always_comb begin
        acc_req_ready_o = 1'b0;
        job_valid_o     = 1'b0;
        rsp_valid_o     = 1'b0;
        rsp_o.tag       = acc_req_i.tag;
        rsp_o.error     = 1'b0;
        rsp_o.data      = '0;
        issue           = 1'b0;
        wr_src          = 1'b0;
        wr_dst          = 1'b0;
        wr_str          = 1'b0;
        wr_rep          = 1'b0;

        if (acc_req_valid_i) begin
            case (acc_req_i.op)
                DMSRC: begin
                    wr_src          = 1'b1;
                    acc_req_ready_o = 1'b1;
                end
                DMDST: begin
                    wr_dst          = 1'b1;
                    acc_req_ready_o = 1'b1;
                end
                DMSTR: begin
                    wr_str          = 1'b1;
                    acc_req_ready_o = 1'b1;
                end
                DMREP: begin
                    wr_rep          = 1'b1;
                    acc_req_ready_o = 1'b1;
                end
                DMCPY: begin
                    // needs room for both the job and its id response
                    if (rsp_ready_i && job_ready_i) begin
                        job_valid_o     = 1'b1;
                        rsp_valid_o     = 1'b1;
                        rsp_o.data      = acc_data_t'(next_id_q);
                        issue           = 1'b1;
                        acc_req_ready_o = 1'b1;
                    end
                end
                DMSTAT: begin
                    case (acc_req_i.argb[1:0])
                        2'd0:    rsp_o.data = acc_data_t'(completed_id_q);
                        2'd1:    rsp_o.data = acc_data_t'(next_id_q);
                        2'd2:    rsp_o.data = acc_data_t'(busy_o);
                        default: rsp_o.data = acc_data_t'(fifo_full_i);
                    endcase
                    rsp_valid_o     = rsp_ready_i;
                    acc_req_ready_o = rsp_ready_i;
                end
                default: begin
                    // unassigned opcode
                    rsp_o.error     = 1'b1;
                    rsp_valid_o     = rsp_ready_i;
                    acc_req_ready_o = rsp_ready_i;
                end
            endcase
        end
    end

    // --------------------
    // registers and counters
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            src_q          <= '0;
            dst_q          <= '0;
            src_stride_q   <= '0;
            dst_stride_q   <= '0;
            reps_q         <= '0;
            next_id_q      <= tf_id_t'(1);
            completed_id_q <= '0;
        end else begin
            if (wr_src) src_q <= addr_t'(acc_req_i.arga);
            if (wr_dst) dst_q <= addr_t'(acc_req_i.arga);
            if (wr_str) begin
                src_stride_q <= rep_t'(acc_req_i.arga);
                dst_stride_q <= rep_t'(acc_req_i.argb);
            end
            if (wr_rep) reps_q <= rep_t'(acc_req_i.arga);
            if (issue) next_id_q <= next_id_q + tf_id_t'(1);
            if (job_done_i) completed_id_q <= completed_id_q + tf_id_t'(1);
        end
    end

endmodule

// File: dma_fe_pkg.sv
/*
  shared widths, types and opcodes of the DMA instruction frontend
  single channel, 32-bit addresses, register forms of copy and status only
  op codes 6 and 7 are not assigned and get an error response
*/
package dma_fe_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int unsigned ADDR_W         = 32;
    localparam int unsigned LEN_W          = 32;
    localparam int unsigned REP_W          = 32;
    localparam int unsigned TF_ID_W        = 32;
    localparam int unsigned ACC_ID_W       = 5;
    localparam int unsigned ACC_DATA_W     = 32;
    localparam int unsigned REQ_FIFO_DEPTH = 3;
    localparam int unsigned REQ_FIFO_PTR_W = $clog2(REQ_FIFO_DEPTH);
    localparam int unsigned REQ_FIFO_CNT_W = $clog2(REQ_FIFO_DEPTH + 1);

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [LEN_W-1:0]      len_t;
    typedef logic [REP_W-1:0]      rep_t;
    typedef logic [TF_ID_W-1:0]    tf_id_t;
    typedef logic [ACC_ID_W-1:0]   acc_id_t;
    typedef logic [ACC_DATA_W-1:0] acc_data_t;

    // instruction opcodes
    typedef enum logic [2:0] {
        DMSRC  = 3'd0,
        DMDST  = 3'd1,
        DMCPY  = 3'd2,
        DMSTAT = 3'd3,
        DMSTR  = 3'd4,
        DMREP  = 3'd5
    } dma_op_e;

    // --------------------
    // channel payloads
    // --------------------
    typedef struct packed {
        acc_id_t   tag;
        dma_op_e   op;
        acc_data_t arga;
        acc_data_t argb;
    } acc_req_t;

    typedef struct packed {
        acc_id_t   tag;
        logic      error;
        acc_data_t data;
    } acc_rsp_t;

    typedef struct packed {
        addr_t src;
        addr_t dst;
        len_t  len;
    } burst_req_t;

    typedef struct packed {
        burst_req_t burst;
        rep_t       src_stride;
        rep_t       dst_stride;
        rep_t       reps;
    } nd_job_t;

endpackage
